/* vlog.f */
design/scope_pkg.sv
design/extremes_tracker.sv
design/column_ram.sv
design/trace_buffer.sv
design/raster_counter.sv
design/trace_renderer.sv
design/vga_scope.sv
testbench/tb_vga_scope.sv

/* testbench/tb_vga_scope.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_vga_scope import scope_pkg::*; ();

	typedef struct packed {
		logic active;
		column_t x;
		row_t y;
	} probe_t;

	logic clk;
	logic reset;
	logic blank;
	logic vsync;
	logic ad_strobe;
	channel_samples_t samples;
	color_t red;
	color_t green;
	color_t blue;

	probe_t probe;
	probe_t pipe [3];
	logic [31:0] rng = 32'hb5b37007;
	int cur_test;
	int timeouts;
	int test_checks [5];
	int test_errors [5];
	string test_names [5] = '{"top_rows_black", "single_frame", "ring_order", "priority",
		"unstrobed_extreme"};

	// model of the tracker and of the written columns
	int run_min [4];
	int run_max [4];
	int held_min [4];
	int held_max [4];
	logic prev_vsync;
	trace_column_t written [$];

	vga_scope DUT (
		.clk(clk),
		.reset(reset),
		.blank(blank),
		.vsync(vsync),
		.samples(samples),
		.ad_strobe(ad_strobe),
		.red(red),
		.green(green),
		.blue(blue)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	function automatic rgb_t expected_pixel(int x, int y);
		rgb_t colors [4];
		trace_column_t c;
		int h;
		colors = '{COLOR_A0, COLOR_A1, COLOR_B0, COLOR_B1};
		if (y < 224) return COLOR_BLACK;
		// column x shows write number n - 800 + x
		c = written[written.size() - 800 + x];
		for (int ch = 0; ch < 4; ch++) begin
			h = y - (224 + 32 * ch);
			if (h >= 0 && h >= c.min[ch] && h <= c.max[ch]) return colors[ch];
		end
		if (x % 64 == 63 || y % 32 == 0) return COLOR_GRID;
		return COLOR_BLACK;
	endfunction

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////
	// mode 0 random, 1 overlapping spans, 2 narrow strobed data with extremes between strobes
	task automatic make_samples(int mode, logic strobed, int x, output int v [4]);
		int lo [4];
		int hi [4];
		lo = '{40, 8, 0, 0};
		hi = '{100, 80, 60, 40};
		for (int ch = 0; ch < 4; ch++) begin
			rng = xorshift32(rng);
			if (mode == 2 && !strobed) v[ch] = (x % 2) ? 12'hfff : 12'h000;
			else if (mode == 2) v[ch] = {8'h40 + rng[5:0], rng[19:16]};
			else if (mode == 1) v[ch] = {8'(lo[ch] + rng[15:0] % (hi[ch] - lo[ch] + 1)),
				rng[19:16]};
			else v[ch] = rng[11:0];
		end
	endtask

	task automatic model_strobe(int v [4], logic vs);
		for (int ch = 0; ch < 4; ch++) begin
			if (vs && !prev_vsync) begin
				held_min[ch] = run_min[ch];
				held_max[ch] = run_max[ch];
				run_min[ch] = v[ch];
				run_max[ch] = v[ch];
			end else begin
				if (v[ch] < run_min[ch]) run_min[ch] = v[ch];
				if (v[ch] > run_max[ch]) run_max[ch] = v[ch];
			end
		end
		prev_vsync = vs;
	endtask

	task automatic drive_cycle(logic b, logic vs, logic st, int v [4], logic act, int x, int y);
		blank = b;
		vsync = vs;
		ad_strobe = st;
		samples = {sample_t'(v[0]), sample_t'(v[1]), sample_t'(v[2]), sample_t'(v[3])};
		probe = '{act, column_t'(x), row_t'(y)};
		@(negedge clk);
	endtask

	task automatic run_frame(int mode, int next_mode);
		int v [4];
		logic st;
		trace_column_t c;
		for (int line = 0; line < 480; line++) begin
			for (int x = 0; x < 816; x++) begin
				st = (x < 800) && (line % 40 == 5) && (x % 50 == 13);
				make_samples(mode, st, x, v);
				if (st) model_strobe(v, 1'b0);
				drive_cycle(x >= 800, 1'b0, st, v, x < 800, x, line);
			end
		end
		// four blank lines, vsync on the middle two, one strobe inside vsync
		for (int line = 0; line < 4; line++) begin
			for (int x = 0; x < 816; x++) begin
				st = (line == 1) && (x == 100);
				make_samples(st ? next_mode : mode, st, x, v);
				if (st) model_strobe(v, 1'b1);
				drive_cycle(1'b1, line == 1 || line == 2, st, v, 1'b0, 0, 0);
			end
		end
		for (int ch = 0; ch < 4; ch++) begin
			c.min[ch] = level_t'(held_min[ch] >> 4);
			c.max[ch] = level_t'(held_max[ch] >> 4);
		end
		written.push_back(c);
	endtask

	task automatic wait_pipe_drained();
		int v [4];
		int n;
		v = '{0, 0, 0, 0};
		n = 0;
		while ((pipe[0].active || pipe[1].active || pipe[2].active) && n < 16) begin
			drive_cycle(1'b1, 1'b0, 1'b0, v, 1'b0, 0, 0);
			n++;
		end
		if (pipe[0].active || pipe[1].active || pipe[2].active) begin
			$display("timeout: pixel check pipeline did not drain");
			timeouts++;
		end
	endtask

	task automatic report_test(int t);
		if (test_checks[t] == 0) begin
			$display("test %s ran no pixel checks", test_names[t]);
			test_errors[t]++;
		end
		$display("test %s: %0d checks, %0d errors", test_names[t], test_checks[t],
			test_errors[t]);
	endtask

	////////////////////////////////////////
	// pixel comparison 3 cycles behind the raster
	////////////////////////////////////////
	always @(posedge clk) begin
		pipe[0] <= probe;
		pipe[1] <= pipe[0];
		pipe[2] <= pipe[1];
	end

	always @(negedge clk) begin : compare
		rgb_t got;
		rgb_t exp;
		int t;
		if (pipe[2].active) begin
			got = {red, green, blue};
			if (pipe[2].y < 224) t = 0;
			else if (written.size() - 800 + int'(pipe[2].x) < 0) t = -1;
			else t = cur_test;
			if (t >= 0) begin
				exp = expected_pixel(pipe[2].x, pipe[2].y);
				test_checks[t]++;
				assert (got === exp) else begin
					if (test_errors[t] < 10) begin
						$display("FAILED %s at (%0d,%0d): expected %h actual %h",
							test_names[t], pipe[2].x, pipe[2].y, exp, got);
					end
					test_errors[t]++;
				end
			end
		end
	end

	initial begin
		int v [4];
		int total;
		v = '{0, 0, 0, 0};
		reset = 1'b1;
		drive_cycle(1'b0, 1'b0, 1'b0, v, 1'b0, 0, 0);
		@(negedge clk);
		reset = 1'b0;
		for (int ch = 0; ch < 4; ch++) begin
			run_min[ch] = 0;
			run_max[ch] = 0;
			held_min[ch] = 0;
			held_max[ch] = 0;
		end
		prev_vsync = 1'b0;
		timeouts = 0;
		// frame f displays the data captured in frame f - 1
		for (int f = 0; f < 9; f++) begin
			cur_test = (f <= 1) ? 1 : (f <= 6) ? 2 : (f == 7) ? 3 : 4;
			run_frame((f == 6) ? 1 : (f == 7) ? 2 : 0, (f == 5) ? 1 : (f == 6) ? 2 : 0);
			wait_pipe_drained();
			if (f == 1 || f >= 6) report_test(cur_test);
		end
		report_test(0);
		total = timeouts;
		for (int t = 0; t < 5; t++) total += test_errors[t];
		$display("tests: 5, errors: %0d, timeouts: %0d", total - timeouts, timeouts);
		if (total == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* design/vga_scope.sv */
`timescale 1ns/100ps
`default_nettype none

module vga_scope import scope_pkg::*; (
	input logic clk,
	input logic reset,
	input logic blank,
	input logic vsync,
	input channel_samples_t samples,
	input logic ad_strobe,
	output color_t red,
	output color_t green,
	output color_t blue
);

	frame_extremes_t frame_extremes;
	pixel_pos_t pos;
	pixel_pos_t column_pos;
	trace_column_t column;
	rgb_t pixel;

	// capture side keeps one min/max set per frame
	extremes_tracker u_extremes_tracker (
		.clk(clk),
		.reset(reset),
		.vsync(vsync),
		.ad_strobe(ad_strobe),
		.samples(samples),
		.frame_extremes(frame_extremes)
	);

	raster_counter u_raster_counter (
		.clk(clk),
		.reset(reset),
		.blank(blank),
		.vsync(vsync),
		.pos(pos)
	);

	trace_buffer u_trace_buffer (
		.clk(clk),
		.reset(reset),
		.vsync(vsync),
		.frame_extremes(frame_extremes),
		.pos(pos),
		.column(column),
		.column_pos(column_pos)
	);

	trace_renderer u_trace_renderer (
		.clk(clk),
		.reset(reset),
		.column(column),
		.column_pos(column_pos),
		.pixel(pixel)
	);

	assign red = pixel.red;
	assign green = pixel.green;
	assign blue = pixel.blue;

endmodule

`default_nettype wire

/* design/trace_renderer.sv */
`timescale 1ns/100ps
`default_nettype none

module trace_renderer import scope_pkg::*; (
	input logic clk,
	input logic reset,
	input trace_column_t column,
	input pixel_pos_t column_pos,
	output rgb_t pixel
);

	logic grid_flag;
	logic [3:0] trace_flags;
	logic in_band;

	// height of the row above the channel base is checked against the stored span
	function automatic logic in_span(row_t row, row_t offset, level_t lo, level_t hi);
		row_t height;
		height = row - offset;
		return (row >= offset) && (height >= row_t'(lo)) && (height <= row_t'(hi));
	endfunction

	assign in_band = (column_pos.y >= SCOPE_TOP_ROW) && (column_pos.y < SCREEN_ROWS);

	////////////////////////////////////////
	// pixel decisions
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			grid_flag <= 1'b0;
			trace_flags <= '0;
		end else if (in_band) begin
			grid_flag <= (column_pos.x % GRID_COLUMN_PERIOD == GRID_COLUMN_PERIOD - 1)
				|| (column_pos.y % GRID_ROW_PERIOD == 0);
			for (int ch = 0; ch < 4; ch++) begin
				trace_flags[ch] <= in_span(column_pos.y, CHANNEL_ROW_OFFSET[ch],
					column.min[ch], column.max[ch]);
			end
		end else begin
			grid_flag <= 1'b0;
			trace_flags <= '0;
		end
	end

	////////////////////////////////////////
	// colour priority
	////////////////////////////////////////
	always_comb begin
		if (trace_flags[0]) begin
			pixel = COLOR_A0;
		end else if (trace_flags[1]) begin
			pixel = COLOR_A1;
		end else if (trace_flags[2]) begin
			pixel = COLOR_B0;
		end else if (trace_flags[3]) begin
			pixel = COLOR_B1;
		end else if (grid_flag) begin
			// grid stays behind every trace
			pixel = COLOR_GRID;
		end else begin
			pixel = COLOR_BLACK;
		end
	end

endmodule

`default_nettype wire

/* design/raster_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module raster_counter import scope_pkg::*; (
	input logic clk,
	input logic reset,
	input logic blank,
	input logic vsync,
	output pixel_pos_t pos
);

	logic blank_d;

	always_ff @(posedge clk) begin
		if (reset) begin
			blank_d <= 1'b0;
			pos <= '0;
		end else begin
			blank_d <= blank;
			// column restarts at every blank
			pos.x <= blank ? '0 : pos.x + 1'b1;
			// row steps at the end of each active line
			if (vsync) begin
				pos.y <= '0;
			end else if (blank && !blank_d) begin
				pos.y <= pos.y + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* design/trace_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module trace_buffer import scope_pkg::*; (
	input logic clk,
	input logic reset,
	input logic vsync,
	input frame_extremes_t frame_extremes,
	input pixel_pos_t pos,
	output trace_column_t column,
	output pixel_pos_t column_pos
);

	logic vsync_d;
	logic write_enable;
	column_t write_ptr;
	column_t read_column;
	trace_column_t write_data;
	pixel_pos_t pos_d;

	function automatic column_t wrap(logic [10:0] sum);
		return (sum >= TRACE_COLUMNS) ? column_t'(sum - TRACE_COLUMNS) : column_t'(sum);
	endfunction

	function automatic level_t level(sample_t s);
		return s[SAMPLE_BITS-1 -: LEVEL_BITS];
	endfunction

	always_comb begin
		write_data.max[0] = level(frame_extremes.max.a0);
		write_data.max[1] = level(frame_extremes.max.a1);
		write_data.max[2] = level(frame_extremes.max.b0);
		write_data.max[3] = level(frame_extremes.max.b1);
		write_data.min[0] = level(frame_extremes.min.a0);
		write_data.min[1] = level(frame_extremes.min.a1);
		write_data.min[2] = level(frame_extremes.min.b0);
		write_data.min[3] = level(frame_extremes.min.b1);
	end

	// one column per frame is written just after vsync ends
	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_d <= 1'b0;
			write_enable <= 1'b0;
			write_ptr <= column_t'(TRACE_COLUMNS - 1);
		end else begin
			vsync_d <= vsync;
			write_enable <= vsync_d && !vsync;
			if (vsync_d && !vsync) begin
				write_ptr <= wrap({1'b0, write_ptr} + 11'd1);
			end
		end
	end

	// oldest column sits right after the newest one
	always_ff @(posedge clk) begin
		read_column <= wrap({1'b0, write_ptr} + 11'd1 + {1'b0, pos.x});
		pos_d <= pos;
		column_pos <= pos_d;
	end

	column_ram u_column_ram (
		.clk(clk),
		.write_enable(write_enable),
		.write_column(write_ptr),
		.write_data(write_data),
		.read_column(read_column),
		.read_data(column)
	);

endmodule

`default_nettype wire

/* design/column_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module column_ram import scope_pkg::*; (
	input logic clk,
	input logic write_enable,
	input column_t write_column,
	input trace_column_t write_data,
	input column_t read_column,
	output trace_column_t read_data
);

	// one packed trace column per screen column
	trace_column_t mem [TRACE_COLUMNS];

	always_ff @(posedge clk) begin
		if (write_enable) begin
			mem[write_column] <= write_data;
		end
		// registered read returns old data on a same-address write
		read_data <= mem[read_column];
	end

endmodule

`default_nettype wire

/* design/extremes_tracker.sv */
`timescale 1ns/100ps
`default_nettype none

module extremes_tracker import scope_pkg::*; (
	input logic clk,
	input logic reset,
	input logic vsync,
	input logic ad_strobe,
	input channel_samples_t samples,
	output frame_extremes_t frame_extremes
);

	// vsync as seen by the previous strobe
	logic vsync_at_strobe;
	channel_samples_t run_min;
	channel_samples_t run_max;

	// keep the held value or take the sample if it lies further out
	function automatic sample_t pick(sample_t held, sample_t s, logic larger);
		logic further;
		further = larger ? (s > held) : (s < held);
		return further ? s : held;
	endfunction

	function automatic channel_samples_t widen(channel_samples_t held,
			channel_samples_t s, logic larger);
		channel_samples_t r;
		r.a0 = pick(held.a0, s.a0, larger);
		r.a1 = pick(held.a1, s.a1, larger);
		r.b0 = pick(held.b0, s.b0, larger);
		r.b1 = pick(held.b1, s.b1, larger);
		return r;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_at_strobe <= 1'b0;
			run_min <= '0;
			run_max <= '0;
			frame_extremes <= '0;
		end else if (ad_strobe) begin
			vsync_at_strobe <= vsync;
			if (vsync && !vsync_at_strobe) begin
				// hold the finished frame and restart from this sample
				frame_extremes.min <= run_min;
				frame_extremes.max <= run_max;
				run_min <= samples;
				run_max <= samples;
			end else begin
				run_min <= widen(run_min, samples, 1'b0);
				run_max <= widen(run_max, samples, 1'b1);
			end
		end
	end

endmodule

`default_nettype wire

/* design/scope_pkg.sv */
`default_nettype none

package scope_pkg;

	////////////////////////////////////////
	// geometry and sample widths
	////////////////////////////////////////
	localparam int SAMPLE_BITS = 12;
	localparam int LEVEL_BITS = 8;
	localparam int TRACE_COLUMNS = 800;
	localparam int SCREEN_ROWS = 480;
	localparam int SCOPE_TOP_ROW = 224;
	localparam int GRID_COLUMN_PERIOD = 64;
	localparam int GRID_ROW_PERIOD = 32;

	typedef logic [SAMPLE_BITS-1:0] sample_t;
	typedef logic [LEVEL_BITS-1:0] level_t;
	typedef logic [9:0] column_t;
	typedef logic [9:0] row_t;
	typedef logic [7:0] color_t;

	// base row of a0, a1, b0, b1 (index 0 to 3)
	localparam row_t CHANNEL_ROW_OFFSET [4] = '{10'd224, 10'd256, 10'd288, 10'd320};

	typedef struct packed {
		sample_t a0;
		sample_t a1;
		sample_t b0;
		sample_t b1;
	} channel_samples_t;

	typedef struct packed {
		channel_samples_t max;
		channel_samples_t min;
	} frame_extremes_t;

	// index 0 is a0, index 3 is b1
	typedef struct packed {
		level_t [3:0] max;
		level_t [3:0] min;
	} trace_column_t;

	typedef struct packed {
		column_t x;
		row_t y;
	} pixel_pos_t;

	typedef struct packed {
		color_t red;
		color_t green;
		color_t blue;
	} rgb_t;

	////////////////////////////////////////
	// palette
	////////////////////////////////////////
	localparam rgb_t COLOR_A0 = 24'hffffff;
	localparam rgb_t COLOR_A1 = 24'hff0000;
	localparam rgb_t COLOR_B0 = 24'h00ff00;
	localparam rgb_t COLOR_B1 = 24'h0000ff;
	localparam rgb_t COLOR_GRID = 24'h808080;
	localparam rgb_t COLOR_BLACK = 24'h000000;

endpackage

`default_nettype wire
